//--- verilog/rt_pkg.sv
`default_nettype none

package rt_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [127:0] vword_t;
    typedef logic [4:0]   sreg_addr_t;
    typedef logic [3:0]   vreg_addr_t;
    typedef logic [5:0]   opcode_t;
    typedef logic [2:0]   cls_t;

    localparam int NUM_SREGS = 32;
    localparam int NUM_VREGS = 16;
    localparam int LANES     = 4;
    localparam int LANE_W    = 32;

    // Immediate format, bit 31 set
    localparam opcode_t OP_JUMP = 6'b111011;
    localparam opcode_t OP_ADDI = 6'b100000;
    localparam opcode_t OP_END  = 6'b111111;

    // Register format classes in bits 30:28
    localparam cls_t CLS_VADD  = 3'b000;
    localparam cls_t CLS_VXOR  = 3'b001;
    localparam cls_t CLS_VFADD = 3'b010;
    localparam cls_t CLS_LOGIC = 3'b011;
    localparam cls_t CLS_SADD  = 3'b100;
    localparam cls_t CLS_SSUB  = 3'b101;

    // Class 110 with all fields zero
    localparam word_t NOP_INSTR = 32'h6000_0000;

    localparam sreg_addr_t PC_REG = 5'd31;

    localparam int QUANTUM_CYCLES = 48;
    localparam int DRAIN_CYCLES   = 2;
    localparam int QCNT_W         = $clog2(QUANTUM_CYCLES);
    localparam int DCNT_W         = $clog2(DRAIN_CYCLES + 1);

    typedef enum logic [2:0] {
        RUN,
        DRAIN,
        SWITCH,
        KERNEL,
        DONE
    } run_state_t;

endpackage

`default_nettype wire

//--- verilog/rt_decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rt_decode_if import rt_pkg::*; ();

    logic       valid;
    cls_t       cls;
    logic [1:0] logic_sel;
    logic       s_wen;
    logic       v_wen;
    sreg_addr_t s_dest;
    vreg_addr_t v_dest;
    word_t      s_op1;
    word_t      s_op2;
    vword_t     v_op1;
    vword_t     v_op2;
    word_t      imm_add;
    logic       is_addi;

    modport src (
        output valid, cls, logic_sel, s_wen, v_wen, s_dest, v_dest,
        output s_op1, s_op2, v_op1, v_op2, imm_add, is_addi
    );

    modport dst (
        input valid, cls, logic_sel, s_wen, v_wen, s_dest, v_dest,
        input s_op1, s_op2, v_op1, v_op2, imm_add, is_addi
    );

endinterface

`default_nettype wire

//--- verilog/rt_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rt_fetch import rt_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fetch_enable,
    input  word_t imem_data,
    output word_t imem_addr,
    output word_t instr,
    output word_t pc_plus4,
    output logic  halt_seen
);

    word_t   pc;
    word_t   pc_inc;
    word_t   next_pc;
    opcode_t opcode;
    logic    is_jump;
    logic    is_end;

    assign opcode    = imem_data[31:26];
    assign is_jump   = (opcode == OP_JUMP);
    assign is_end    = (opcode == OP_END);
    assign pc_inc    = pc + 32'd4;
    assign imem_addr = pc;
    assign halt_seen = is_end;

    // PC holds on stall and at END
    always_comb begin
        if (!fetch_enable || is_end) begin
            next_pc = pc;
        end else if (is_jump) begin
            next_pc = {16'h0000, imem_data[15:0]};
        end else begin
            next_pc = pc_inc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    //////////////////////////////////////////////////
    // IF/DE register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr    <= NOP_INSTR;
            pc_plus4 <= '0;
        end else begin
            pc_plus4 <= pc_inc;
            // Jump and END go no further than fetch
            if (!fetch_enable || is_jump || is_end) begin
                instr <= NOP_INSTR;
            end else begin
                instr <= imem_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rt_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rt_decode import rt_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      instr,
    input  word_t      pc_plus4,
    output sreg_addr_t rf_s_addr1,
    output sreg_addr_t rf_s_addr2,
    output vreg_addr_t rf_v_addr1,
    output vreg_addr_t rf_v_addr2,
    input  word_t      rf_s_data1,
    input  word_t      rf_s_data2,
    input  vword_t     rf_v_data1,
    input  vword_t     rf_v_data2,
    rt_decode_if.src   dec
);

    logic       is_imm;
    cls_t       cls;
    sreg_addr_t dest;
    sreg_addr_t src1;
    sreg_addr_t src2;
    word_t      s_val1;
    word_t      s_val2;
    logic       s1_en, s2_en, v1_en, v2_en;
    logic       s_wen, v_wen, is_addi;
    logic       s_wen_kept;

    assign is_imm = instr[31];
    assign cls    = instr[30:28];
    assign dest   = instr[25:21];
    assign src1   = instr[20:16];
    assign src2   = instr[15:11];

    assign rf_s_addr1 = src1;
    assign rf_s_addr2 = src2;
    assign rf_v_addr1 = src1[3:0];
    assign rf_v_addr2 = src2[3:0];

    // r31 reads as PC+4 of this instruction
    assign s_val1 = (src1 == PC_REG) ? pc_plus4 : rf_s_data1;
    assign s_val2 = (src2 == PC_REG) ? pc_plus4 : rf_s_data2;

    always_comb begin
        s1_en   = 1'b0;
        s2_en   = 1'b0;
        v1_en   = 1'b0;
        v2_en   = 1'b0;
        s_wen   = 1'b0;
        v_wen   = 1'b0;
        is_addi = 1'b0;
        if (!is_imm) begin
            case (cls)
                CLS_VADD, CLS_VXOR: begin
                    v1_en = 1'b1;
                    v2_en = 1'b1;
                    v_wen = 1'b1;
                end
                CLS_VFADD: begin
                    v1_en = 1'b1;
                    s2_en = 1'b1;
                    v_wen = 1'b1;
                end
                CLS_LOGIC, CLS_SADD, CLS_SSUB: begin
                    s1_en = 1'b1;
                    s2_en = 1'b1;
                    s_wen = 1'b1;
                end
                default: begin
                    s_wen = 1'b0;
                end
            endcase
        end else if (instr[31:26] == OP_ADDI) begin
            s1_en   = 1'b1;
            s_wen   = 1'b1;
            is_addi = 1'b1;
        end
    end

    // r31 is read-only
    assign s_wen_kept = s_wen && (dest != PC_REG);

    //////////////////////////////////////////////////
    // DE/EX register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec.valid   <= 1'b0;
            dec.s_wen   <= 1'b0;
            dec.v_wen   <= 1'b0;
            dec.is_addi <= 1'b0;
        end else begin
            dec.valid   <= s_wen_kept | v_wen;
            dec.s_wen   <= s_wen_kept;
            dec.v_wen   <= v_wen;
            dec.is_addi <= is_addi;
        end
    end

    always_ff @(posedge clk) begin
        dec.cls       <= cls;
        dec.logic_sel <= instr[1:0];
        dec.s_dest    <= dest;
        dec.v_dest    <= dest[3:0];
        dec.s_op1     <= s1_en ? s_val1 : '0;
        dec.s_op2     <= s2_en ? s_val2 : '0;
        dec.v_op1     <= v1_en ? rf_v_data1 : '0;
        dec.v_op2     <= v2_en ? rf_v_data2 : '0;
        dec.imm_add   <= {{16{instr[15]}}, instr[15:0]};
    end

endmodule

`default_nettype wire

//--- verilog/rt_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rt_regfile import rt_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  sreg_addr_t rf_s_addr1,
    input  sreg_addr_t rf_s_addr2,
    input  vreg_addr_t rf_v_addr1,
    input  vreg_addr_t rf_v_addr2,
    output word_t      rf_s_data1,
    output word_t      rf_s_data2,
    output vword_t     rf_v_data1,
    output vword_t     rf_v_data2,
    input  logic       s_wen,
    input  sreg_addr_t s_waddr,
    input  word_t      s_wdata,
    input  logic       v_wen,
    input  vreg_addr_t v_waddr,
    input  vword_t     v_wdata
);

    word_t  s_regs [NUM_SREGS];
    vword_t v_regs [NUM_VREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SREGS; i++) begin
                s_regs[i] <= '0;
            end
            for (int i = 0; i < NUM_VREGS; i++) begin
                v_regs[i] <= '0;
            end
        end else begin
            if (s_wen) begin
                s_regs[s_waddr] <= s_wdata;
            end
            if (v_wen) begin
                v_regs[v_waddr] <= v_wdata;
            end
        end
    end

    // Write-through, the next instruction sees this cycle's result
    assign rf_s_data1 = (s_wen && s_waddr == rf_s_addr1) ? s_wdata : s_regs[rf_s_addr1];
    assign rf_s_data2 = (s_wen && s_waddr == rf_s_addr2) ? s_wdata : s_regs[rf_s_addr2];
    assign rf_v_data1 = (v_wen && v_waddr == rf_v_addr1) ? v_wdata : v_regs[rf_v_addr1];
    assign rf_v_data2 = (v_wen && v_waddr == rf_v_addr2) ? v_wdata : v_regs[rf_v_addr2];

endmodule

`default_nettype wire

//--- verilog/rt_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rt_execute import rt_pkg::*; (
    rt_decode_if.dst   dec,
    output logic       scalar_wen,
    output logic       vector_wen,
    output sreg_addr_t scalar_wb_address,
    output vreg_addr_t vector_wb_address,
    output word_t      scalar_wb_data,
    output vword_t     vector_wb_data
);

    word_t  s_result;
    vword_t v_result;

    //////////////////////////////////////////////////
    // Scalar unit
    //////////////////////////////////////////////////

    always_comb begin
        s_result = '0;
        if (dec.is_addi) begin
            s_result = dec.s_op1 + dec.imm_add;
        end else begin
            case (dec.cls)
                CLS_LOGIC: begin
                    case (dec.logic_sel)
                        2'b00:   s_result = dec.s_op1 & dec.s_op2;
                        2'b01:   s_result = dec.s_op1 | dec.s_op2;
                        2'b10:   s_result = dec.s_op1 ^ dec.s_op2;
                        default: s_result = ~(dec.s_op1 & dec.s_op2);
                    endcase
                end
                CLS_SADD: s_result = dec.s_op1 + dec.s_op2;
                CLS_SSUB: s_result = dec.s_op1 - dec.s_op2;
                default:  s_result = '0;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Vector unit, four lanes
    //////////////////////////////////////////////////

    always_comb begin
        word_t lane_a;
        word_t lane_b;
        v_result = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_a = dec.v_op1[i*LANE_W +: LANE_W];
            lane_b = dec.v_op2[i*LANE_W +: LANE_W];
            case (dec.cls)
                CLS_VADD:  v_result[i*LANE_W +: LANE_W] = lane_a + lane_b;
                CLS_VXOR:  v_result[i*LANE_W +: LANE_W] = lane_a ^ lane_b;
                // Scalar broadcast to every lane
                CLS_VFADD: v_result[i*LANE_W +: LANE_W] = lane_a + dec.s_op2;
                default:   v_result[i*LANE_W +: LANE_W] = '0;
            endcase
        end
    end

    assign scalar_wen        = dec.valid & dec.s_wen;
    assign vector_wen        = dec.valid & dec.v_wen;
    assign scalar_wb_address = dec.s_dest;
    assign vector_wb_address = dec.v_dest;
    assign scalar_wb_data    = s_result;
    assign vector_wb_data    = v_result;

endmodule

`default_nettype wire

//--- verilog/rt_run_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rt_run_ctrl import rt_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic kernel_mode,
    input  logic halt_seen,
    input  logic quantum_expired,
    input  logic drain_done,
    output logic fetch_enable,
    output logic timer_run,
    output logic timer_drain_start,
    output logic timer_quantum_clear,
    output logic kernel_select,
    output logic context_switch,
    output logic end_program
);

    run_state_t state, state_next;
    run_state_t drain_target, drain_target_next;
    logic       drain_req;

    assign drain_req = halt_seen | kernel_mode | quantum_expired;

    always_comb begin
        state_next        = state;
        drain_target_next = drain_target;
        case (state)
            RUN: begin
                if (drain_req) begin
                    state_next = DRAIN;
                    // Halt first, then kernel, then quantum
                    if (halt_seen) begin
                        drain_target_next = DONE;
                    end else if (kernel_mode) begin
                        drain_target_next = KERNEL;
                    end else begin
                        drain_target_next = SWITCH;
                    end
                end
            end
            DRAIN:   state_next = drain_done ? drain_target : DRAIN;
            SWITCH:  state_next = RUN;
            KERNEL:  state_next = kernel_mode ? KERNEL : RUN;
            DONE:    state_next = DONE;
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= RUN;
            drain_target <= SWITCH;
        end else begin
            state        <= state_next;
            drain_target <= drain_target_next;
        end
    end

    assign fetch_enable        = (state == RUN);
    assign timer_run           = (state == RUN);
    assign timer_drain_start   = (state == RUN) && drain_req;
    assign timer_quantum_clear = (state == SWITCH);
    assign context_switch      = (state == SWITCH);
    assign end_program         = (state == DONE);
    // Debug reads also allowed once the program has ended
    assign kernel_select = (state == KERNEL) || (state == DONE && kernel_mode);

endmodule

`default_nettype wire

//--- verilog/rt_quantum_timer.sv
`timescale 1ns/1ps
`default_nettype none

module rt_quantum_timer import rt_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic drain_start,
    input  logic quantum_clear,
    output logic quantum_expired,
    output logic drain_done
);

    logic [QCNT_W-1:0] q_count;
    logic [DCNT_W-1:0] d_count;

    // Fires on the last RUN cycle of the quantum
    assign quantum_expired = run && (q_count == QCNT_W'(QUANTUM_CYCLES - 1));
    assign drain_done      = (d_count == DCNT_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_count <= '0;
        end else if (quantum_clear || quantum_expired) begin
            q_count <= '0;
        end else if (run) begin
            q_count <= q_count + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_count <= '0;
        end else if (drain_start) begin
            d_count <= DCNT_W'(DRAIN_CYCLES);
        end else if (d_count != '0) begin
            d_count <= d_count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rt_core.sv
`timescale 1ns/1ps
`default_nettype none

module rt_core import rt_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       kernel_mode,
    input  word_t      imem_data,
    input  sreg_addr_t dbg_scalar_addr,
    input  vreg_addr_t dbg_vector_addr,
    output word_t      imem_addr,
    output logic       end_program,
    output logic       context_switch,
    output logic       scalar_wen,
    output sreg_addr_t scalar_wb_address,
    output word_t      scalar_wb_data,
    output logic       vector_wen,
    output vreg_addr_t vector_wb_address,
    output vword_t     vector_wb_data,
    output word_t      dbg_scalar_data,
    output vword_t     dbg_vector_data
);

    word_t      instr;
    word_t      pc_plus4;
    logic       fetch_enable;
    logic       halt_seen;
    logic       quantum_expired;
    logic       drain_done;
    logic       timer_run;
    logic       timer_drain_start;
    logic       timer_quantum_clear;
    logic       kernel_select;
    sreg_addr_t dec_s_addr1, dec_s_addr2, rf_s_addr1;
    vreg_addr_t dec_v_addr1, dec_v_addr2, rf_v_addr1;
    word_t      rf_s_data1, rf_s_data2;
    vword_t     rf_v_data1, rf_v_data2;

    rt_decode_if dec_bus ();

    rt_fetch u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_enable (fetch_enable),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .instr        (instr),
        .pc_plus4     (pc_plus4),
        .halt_seen    (halt_seen)
    );

    rt_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .pc_plus4   (pc_plus4),
        .rf_s_addr1 (dec_s_addr1),
        .rf_s_addr2 (dec_s_addr2),
        .rf_v_addr1 (dec_v_addr1),
        .rf_v_addr2 (dec_v_addr2),
        .rf_s_data1 (rf_s_data1),
        .rf_s_data2 (rf_s_data2),
        .rf_v_data1 (rf_v_data1),
        .rf_v_data2 (rf_v_data2),
        .dec        (dec_bus.src)
    );

    // Debug addresses take read port 1 in kernel mode
    assign rf_s_addr1 = kernel_select ? dbg_scalar_addr : dec_s_addr1;
    assign rf_v_addr1 = kernel_select ? dbg_vector_addr : dec_v_addr1;

    rt_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rf_s_addr1 (rf_s_addr1),
        .rf_s_addr2 (dec_s_addr2),
        .rf_v_addr1 (rf_v_addr1),
        .rf_v_addr2 (dec_v_addr2),
        .rf_s_data1 (rf_s_data1),
        .rf_s_data2 (rf_s_data2),
        .rf_v_data1 (rf_v_data1),
        .rf_v_data2 (rf_v_data2),
        .s_wen      (scalar_wen),
        .s_waddr    (scalar_wb_address),
        .s_wdata    (scalar_wb_data),
        .v_wen      (vector_wen),
        .v_waddr    (vector_wb_address),
        .v_wdata    (vector_wb_data)
    );

    assign dbg_scalar_data = rf_s_data1;
    assign dbg_vector_data = rf_v_data1;

    rt_execute u_execute (
        .dec               (dec_bus.dst),
        .scalar_wen        (scalar_wen),
        .vector_wen        (vector_wen),
        .scalar_wb_address (scalar_wb_address),
        .vector_wb_address (vector_wb_address),
        .scalar_wb_data    (scalar_wb_data),
        .vector_wb_data    (vector_wb_data)
    );

    rt_run_ctrl u_run_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .kernel_mode         (kernel_mode),
        .halt_seen           (halt_seen),
        .quantum_expired     (quantum_expired),
        .drain_done          (drain_done),
        .fetch_enable        (fetch_enable),
        .timer_run           (timer_run),
        .timer_drain_start   (timer_drain_start),
        .timer_quantum_clear (timer_quantum_clear),
        .kernel_select       (kernel_select),
        .context_switch      (context_switch),
        .end_program         (end_program)
    );

    rt_quantum_timer u_timer (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (timer_run),
        .drain_start     (timer_drain_start),
        .quantum_clear   (timer_quantum_clear),
        .quantum_expired (quantum_expired),
        .drain_done      (drain_done)
    );

endmodule

`default_nettype wire

//--- test/rt_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rt_core_props import rt_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       kernel_mode,
    input logic       scalar_wen,
    input logic       vector_wen,
    input logic       context_switch,
    input logic       end_program,
    input run_state_t ctrl_state
);

    logic any_wen;

    assign any_wen = scalar_wen | vector_wen;

    a_switch_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        context_switch |=> !context_switch)
        else $error("context_switch high for more than one cycle");

    // Drain length set by timer and controller together
    a_drain_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ctrl_state == DRAIN) |->
            ($past(ctrl_state == DRAIN, DRAIN_CYCLES)
                && !$past(ctrl_state == DRAIN, DRAIN_CYCLES + 1)))
        else $error("drain did not last DRAIN_CYCLES cycles");

    // Pipeline must be empty once the drain is over
    a_kernel_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (kernel_mode && $past(kernel_mode) && $past(kernel_mode, 2)
            && $past(kernel_mode, DRAIN_CYCLES + 1)) |-> !any_wen)
        else $error("writeback while kernel mode has been held");

    a_end_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        end_program |=> end_program)
        else $error("end_program fell before reset");

    a_end_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        end_program |-> !any_wen)
        else $error("writeback after end_program");

endmodule

bind rt_core rt_core_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .kernel_mode    (kernel_mode),
    .scalar_wen     (scalar_wen),
    .vector_wen     (vector_wen),
    .context_switch (context_switch),
    .end_program    (end_program),
    .ctrl_state     (u_run_ctrl.state)
);

`default_nettype wire

//--- test/rt_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rt_core_tb import rt_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int IMEM_WORDS     = 256;
    localparam int MIX_COUNT      = 150;

    logic       clk;
    logic       rst_n;
    logic       kernel_mode;
    word_t      imem_data;
    sreg_addr_t dbg_scalar_addr;
    vreg_addr_t dbg_vector_addr;
    word_t      imem_addr;
    logic       end_program;
    logic       context_switch;
    logic       scalar_wen;
    sreg_addr_t scalar_wb_address;
    word_t      scalar_wb_data;
    logic       vector_wen;
    vreg_addr_t vector_wb_address;
    vword_t     vector_wb_data;
    word_t      dbg_scalar_data;
    vword_t     dbg_vector_data;

    word_t      imem [IMEM_WORDS];
    int         prog_len;
    word_t      model_s [NUM_SREGS];
    vword_t     model_v [NUM_VREGS];
    sreg_addr_t exp_s_addr [$];
    word_t      exp_s_data [$];
    vreg_addr_t exp_v_addr [$];
    vword_t     exp_v_data [$];

    // Combinational instruction memory
    assign imem_data = imem[imem_addr[9:2]];

    rt_core DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .kernel_mode       (kernel_mode),
        .imem_data         (imem_data),
        .dbg_scalar_addr   (dbg_scalar_addr),
        .dbg_vector_addr   (dbg_vector_addr),
        .imem_addr         (imem_addr),
        .end_program       (end_program),
        .context_switch    (context_switch),
        .scalar_wen        (scalar_wen),
        .scalar_wb_address (scalar_wb_address),
        .scalar_wb_data    (scalar_wb_data),
        .vector_wen        (vector_wen),
        .vector_wb_address (vector_wb_address),
        .vector_wb_data    (vector_wb_data),
        .dbg_scalar_data   (dbg_scalar_data),
        .dbg_vector_data   (dbg_vector_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // Program and reference model
    //////////////////////////////////////////////////

    function automatic word_t encode_reg(cls_t cls, sreg_addr_t d, sreg_addr_t a,
                                         sreg_addr_t b, logic [1:0] sel);
        return {1'b0, cls, 2'b00, d, a, b, 9'd0, sel};
    endfunction

    function automatic word_t encode_imm(opcode_t op, sreg_addr_t d, sreg_addr_t a,
                                         logic [15:0] imm);
        return {op, d, a, imm};
    endfunction

    task automatic emit(input word_t ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    task automatic build_program();
        int         kind;
        cls_t       cls;
        logic [1:0] sel;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {OP_END, 18'd0, 8'(i)};
        end
        prog_len = 0;
        for (int i = 0; i < 31; i++) begin
            emit(encode_imm(OP_ADDI, 5'(i), 5'($urandom), 16'($urandom)));
        end
        // Dropped write to r31, then a read of it
        emit(encode_imm(OP_ADDI, 5'd31, 5'd1, 16'h1234));
        emit(encode_imm(OP_ADDI, 5'd1, 5'd31, 16'h0000));
        for (int i = 0; i < NUM_VREGS; i++) begin
            emit(encode_reg(CLS_VFADD, 5'(i), 5'($urandom), 5'($urandom), 2'b00));
        end
        // Back-to-back dependent chain
        emit(encode_reg(CLS_SADD, 5'd2, 5'd1, 5'd31, 2'b00));
        emit(encode_reg(CLS_SSUB, 5'd3, 5'd2, 5'd1, 2'b00));
        emit(encode_reg(CLS_LOGIC, 5'd4, 5'd3, 5'd2, 2'b10));
        emit(encode_reg(CLS_VADD, 5'd1, 5'd0, 5'd0, 2'b00));
        emit(encode_reg(CLS_VXOR, 5'd2, 5'd1, 5'd0, 2'b00));
        emit(encode_reg(CLS_VFADD, 5'd3, 5'd2, 5'd4, 2'b00));
        // Jump over four writes
        emit(encode_imm(OP_JUMP, 5'd0, 5'd0, 16'((prog_len + 5) * 4)));
        for (int i = 0; i < 4; i++) begin
            emit(encode_imm(OP_ADDI, 5'(10 + i), 5'd0, 16'hbeef));
        end
        for (int i = 0; i < MIX_COUNT; i++) begin
            kind = i % 9;
            case (kind)
                0:       cls = CLS_VADD;
                1:       cls = CLS_VXOR;
                2:       cls = CLS_VFADD;
                7:       cls = CLS_SADD;
                8:       cls = CLS_SSUB;
                default: cls = CLS_LOGIC;
            endcase
            sel = (kind >= 3 && kind <= 6) ? 2'(kind - 3) : 2'($urandom);
            emit(encode_reg(cls, 5'($urandom), 5'($urandom), 5'($urandom), sel));
        end
        emit(encode_imm(OP_END, 5'd0, 5'd0, 16'h0000));
    endtask

    function automatic word_t scalar_operand(sreg_addr_t r, word_t pc);
        return (r == 5'd31) ? pc + 32'd4 : model_s[r];
    endfunction

    task automatic write_scalar(input sreg_addr_t d, input word_t value);
        if (d != 5'd31) begin
            model_s[d] = value;
            exp_s_addr.push_back(d);
            exp_s_data.push_back(value);
        end
    endtask

    task automatic execute_reg(input word_t ins, input word_t pc);
        cls_t       cls;
        sreg_addr_t d;
        word_t      x;
        word_t      y;
        word_t      lane_a;
        word_t      lane_b;
        word_t      lane_r;
        vword_t     vres;
        cls = ins[30:28];
        d   = ins[25:21];
        x   = scalar_operand(ins[20:16], pc);
        y   = scalar_operand(ins[15:11], pc);
        case (cls)
            CLS_VADD, CLS_VXOR, CLS_VFADD: begin
                for (int i = 0; i < LANES; i++) begin
                    lane_a = model_v[ins[19:16]][i*32 +: 32];
                    lane_b = model_v[ins[14:11]][i*32 +: 32];
                    case (cls)
                        CLS_VADD: lane_r = lane_a + lane_b;
                        CLS_VXOR: lane_r = lane_a ^ lane_b;
                        default:  lane_r = lane_a + y;
                    endcase
                    vres[i*32 +: 32] = lane_r;
                end
                model_v[d[3:0]] = vres;
                exp_v_addr.push_back(d[3:0]);
                exp_v_data.push_back(vres);
            end
            CLS_LOGIC: begin
                case (ins[1:0])
                    2'b00:   write_scalar(d, x & y);
                    2'b01:   write_scalar(d, x | y);
                    2'b10:   write_scalar(d, x ^ y);
                    default: write_scalar(d, ~(x & y));
                endcase
            end
            CLS_SADD: write_scalar(d, x + y);
            CLS_SSUB: write_scalar(d, x - y);
            default:  ;
        endcase
    endtask

    task automatic run_model();
        word_t pc;
        word_t ins;
        int    steps;
        logic  running;
        for (int i = 0; i < NUM_SREGS; i++) begin
            model_s[i] = '0;
        end
        for (int i = 0; i < NUM_VREGS; i++) begin
            model_v[i] = '0;
        end
        pc      = '0;
        steps   = 0;
        running = 1'b1;
        while (running && steps < IMEM_WORDS * 2) begin
            ins = imem[pc[9:2]];
            steps++;
            if (ins[31:26] == OP_END) begin
                running = 1'b0;
            end else if (ins[31:26] == OP_JUMP) begin
                pc = {16'h0000, ins[15:0]};
            end else begin
                if (ins[31:26] == OP_ADDI) begin
                    write_scalar(ins[25:21],
                                 scalar_operand(ins[20:16], pc) + {{16{ins[15]}}, ins[15:0]});
                end else if (!ins[31]) begin
                    execute_reg(ins, pc);
                end
                pc = pc + 32'd4;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Writeback monitor
    //////////////////////////////////////////////////

    task automatic check_scalar_writeback();
        sreg_addr_t addr;
        word_t      data;
        if (exp_s_addr.size() == 0) begin
            report_failure("scalar writeback with no instruction left in the model");
        end else begin
            addr = exp_s_addr.pop_front();
            data = exp_s_data.pop_front();
            check_value("scalar_wb_address", 128'(scalar_wb_address), 128'(addr));
            check_value("scalar_wb_data", 128'(scalar_wb_data), 128'(data));
        end
    endtask

    task automatic check_vector_writeback();
        vreg_addr_t addr;
        vword_t     data;
        if (exp_v_addr.size() == 0) begin
            report_failure("vector writeback with no instruction left in the model");
        end else begin
            addr = exp_v_addr.pop_front();
            data = exp_v_data.pop_front();
            check_value("vector_wb_address", 128'(vector_wb_address), 128'(addr));
            check_value("vector_wb_data", vector_wb_data, data);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && scalar_wen) begin
            check_scalar_writeback();
        end
        if (rst_n && vector_wen) begin
            check_vector_writeback();
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int cycles;
        rst_n           = 1'b0;
        kernel_mode     = 1'b0;
        dbg_scalar_addr = '0;
        dbg_vector_addr = '0;
        void'($urandom(5));
        build_program();
        run_model();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Kernel request early in the second quantum
        cycles = 0;
        while (!context_switch && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!context_switch) begin
            report_failure("timed out waiting for the first context switch");
        end
        repeat (10) @(posedge clk);
        #2;
        kernel_mode = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        kernel_mode = 1'b0;

        cycles = 0;
        while (!end_program && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!end_program) begin
            report_failure("timed out waiting for end_program");
        end

        // Debug reads of the whole register file
        @(posedge clk);
        #2;
        kernel_mode = 1'b1;
        for (int i = 0; i < NUM_SREGS; i++) begin
            dbg_scalar_addr = sreg_addr_t'(i);
            dbg_vector_addr = vreg_addr_t'(i % NUM_VREGS);
            @(negedge clk);
            check_value($sformatf("dbg_scalar_data r%0d", i),
                        128'(dbg_scalar_data), 128'(model_s[i]));
            check_value($sformatf("dbg_vector_data v%0d", i % NUM_VREGS),
                        dbg_vector_data, model_v[i % NUM_VREGS]);
            @(posedge clk);
            #2;
        end

        if (exp_s_addr.size() != 0 || exp_v_addr.size() != 0) begin
            $display("DUT never wrote back %0d scalar and %0d vector model results",
                     exp_s_addr.size(), exp_v_addr.size());
            $display("CHECKS FAILED");
            $fatal(1);
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/rt_pkg.sv
verilog/rt_decode_if.sv
verilog/rt_fetch.sv
verilog/rt_decode.sv
verilog/rt_regfile.sv
verilog/rt_execute.sv
verilog/rt_run_ctrl.sv
verilog/rt_quantum_timer.sv
verilog/rt_core.sv
test/rt_core_props.sv
test/rt_core_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the rt_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module rt_core_tb -f tb.f -o rt_core_sim
./obj_dir/rt_core_sim
